/* source/fpu_pkg.sv */
package fpu_pkg;

	// stored field widths of the single-precision format
	localparam int MAN_WIDTH = 23;
	localparam int EXP_WIDTH = 8;
	localparam int EXP_BIAS = 127;

	// signed internal exponent, wide enough to hold overflow and underflow
	localparam int INT_EXP_WIDTH = 10;

	// quiet NaN returned for every NaN result
	localparam logic [31:0] CANONICAL_NAN = 32'h7fc00000;

	// rounding modes, encoded as in RISC-V
	typedef enum logic [2:0] {
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3,
		RMM = 3'd4
	} rounding_mode_t;

endpackage

/* source/fpu_result_if.sv */
interface fpu_result_if import fpu_pkg::*; ();

	// handshake
	logic valid;
	logic ready;

	// unrounded product, hidden bit at the top of man
	rounding_mode_t rm;
	logic [MAN_WIDTH:0] man;
	logic signed [INT_EXP_WIDTH-1:0] exp;
	logic sgn;
	logic round_bit;
	logic sticky_bit;

	// packed special value that bypasses rounding
	logic skip_round;
	logic iv;

	modport producer (
		output valid, rm, man, exp, sgn, round_bit, sticky_bit, skip_round, iv,
		input ready
	);

	modport consumer (
		input valid, rm, man, exp, sgn, round_bit, sticky_bit, skip_round, iv,
		output ready
	);

endinterface

/* source/rshifter.sv */
module rshifter #(
	parameter int WIDTH = 25,
	parameter int SEL_WIDTH = 5
) (
	input logic [WIDTH-1:0] in,
	input logic [SEL_WIDTH-1:0] sel,
	output logic [WIDTH-1:0] out,
	output logic sticky_bit
);

	// ones in every position that the shift pushes out
	logic [WIDTH-1:0] lost_mask;

	always_comb begin
		out = in >> sel;
		lost_mask = ~({WIDTH{1'b1}} << sel);
		// anything shifted past bit 0 ends up in sticky
		sticky_bit = |(in & lost_mask);
	end

endmodule

/* source/rounding_logic.sv */
module rounding_logic import fpu_pkg::*; #(
	parameter int WIDTH = 23
) (
	input rounding_mode_t rm,
	input logic [WIDTH-1:0] in,
	input logic round_bit,
	input logic sticky_bit,
	input logic sgn,
	output logic [WIDTH-1:0] out,
	output logic carry,
	output logic inexact
);

	logic round_up;

	assign inexact = round_bit || sticky_bit;

	// increment decision per mode
	always_comb begin
		case (rm)
			RNE: round_up = round_bit && (sticky_bit || in[0]);
			RTZ: round_up = 1'b0;
			RDN: round_up = sgn && inexact;
			RUP: round_up = !sgn && inexact;
			RMM: round_up = round_bit;
			default: round_up = 1'b0;
		endcase
	end

	// carry out means the mantissa wrapped to zero
	assign {carry, out} = {1'b0, in} + {{WIDTH{1'b0}}, round_up};

endmodule

/* source/fpu_multiplier.sv */
module fpu_multiplier import fpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] operand_a,
	input logic [31:0] operand_b,
	input rounding_mode_t rm,
	fpu_result_if.producer res
);

	localparam int PROD_WIDTH = 2 * (MAN_WIDTH + 1);

	logic sgn_a;
	logic sgn_b;
	logic sgn_r;
	logic [EXP_WIDTH-1:0] exp_a;
	logic [EXP_WIDTH-1:0] exp_b;
	logic [MAN_WIDTH-1:0] man_a;
	logic [MAN_WIDTH-1:0] man_b;

	logic zero_a;
	logic zero_b;
	logic inf_a;
	logic inf_b;
	logic nan_a;
	logic nan_b;
	logic snan_a;
	logic snan_b;
	logic inf_times_zero;
	logic special;
	logic special_iv;
	logic [31:0] special_val;

	logic [PROD_WIDTH-1:0] product;
	logic [PROD_WIDTH-1:0] product_norm;
	logic signed [INT_EXP_WIDTH-1:0] exp_unbiased;

	assign {sgn_a, exp_a, man_a} = operand_a;
	assign {sgn_b, exp_b, man_b} = operand_b;
	assign sgn_r = sgn_a ^ sgn_b;

	// denormal operands count as zero
	assign zero_a = exp_a == '0;
	assign zero_b = exp_b == '0;
	assign inf_a = (&exp_a) && (man_a == '0);
	assign inf_b = (&exp_b) && (man_b == '0);
	assign nan_a = (&exp_a) && (|man_a);
	assign nan_b = (&exp_b) && (|man_b);
	// quiet bit clear means signaling
	assign snan_a = nan_a && !man_a[MAN_WIDTH-1];
	assign snan_b = nan_b && !man_b[MAN_WIDTH-1];

	assign inf_times_zero = (inf_a && zero_b) || (inf_b && zero_a);
	assign special = nan_a || nan_b || inf_a || inf_b || zero_a || zero_b;

	// packed result for the special cases
	always_comb begin
		special_iv = 1'b0;
		if (nan_a || nan_b || inf_times_zero) begin
			special_val = CANONICAL_NAN;
			special_iv = snan_a || snan_b || inf_times_zero;
		end else if (inf_a || inf_b) begin
			special_val = {sgn_r, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};
		end else begin
			special_val = {sgn_r, {(EXP_WIDTH + MAN_WIDTH){1'b0}}};
		end
	end

	// significand product lies in [1, 4)
	assign product = {1'b1, man_a} * {1'b1, man_b};

	always_comb begin
		// top bit set means the product is in [2, 4)
		if (product[PROD_WIDTH-1])
			product_norm = product;
		else
			product_norm = product << 1;
		exp_unbiased = INT_EXP_WIDTH'(exp_a) + INT_EXP_WIDTH'(exp_b)
			- INT_EXP_WIDTH'(2 * EXP_BIAS) + INT_EXP_WIDTH'(product[PROD_WIDTH-1]);
	end

	assign in_ready = res.ready;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			res.valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			res.valid <= 1'b1;
		end else if (res.ready) begin
			res.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			res.rm <= rm;
			res.skip_round <= special;
			res.iv <= special_iv;
			if (special) begin
				// fields laid out so the post processor packs them unchanged
				res.sgn <= special_val[31];
				res.exp <= INT_EXP_WIDTH'(special_val[MAN_WIDTH +: EXP_WIDTH]);
				res.man <= {1'b0, special_val[MAN_WIDTH-1:0]};
				res.round_bit <= 1'b0;
				res.sticky_bit <= 1'b0;
			end else begin
				res.sgn <= sgn_r;
				res.exp <= exp_unbiased;
				res.man <= product_norm[PROD_WIDTH-1 -: MAN_WIDTH + 1];
				res.round_bit <= product_norm[MAN_WIDTH];
				res.sticky_bit <= |product_norm[MAN_WIDTH-1:0];
			end
		end
	end

endmodule

/* source/post_processor.sv */
module post_processor import fpu_pkg::*; (
	input logic clk,
	input logic reset,
	fpu_result_if.consumer src,
	output logic out_valid,
	input logic out_ready,
	output logic [31:0] float_out,
	output logic iv,
	output logic of,
	output logic uf,
	output logic ie
);

	// hidden bit, stored mantissa and round bit go through the shifter together
	localparam int SHIFT_WIDTH = MAN_WIDTH + 2;
	localparam int SHIFT_SEL_WIDTH = $clog2(SHIFT_WIDTH);

	rounding_mode_t reg_rm;
	logic [MAN_WIDTH-1:0] reg_man;
	logic [INT_EXP_WIDTH-1:0] reg_exp;
	logic reg_sgn;
	logic reg_round_bit;
	logic reg_sticky_bit;
	logic reg_skip_round;
	logic reg_equal;
	logic reg_less;
	logic reg_iv;

	logic signed [INT_EXP_WIDTH-1:0] exp_biased;
	logic [INT_EXP_WIDTH-1:0] exp_adj;
	logic [INT_EXP_WIDTH-1:0] offset;
	logic equal;
	logic less;
	logic [SHIFT_SEL_WIDTH-1:0] shift_sel;

	logic [SHIFT_WIDTH-1:0] shifter_out;
	logic shift_sticky;

	logic [MAN_WIDTH-1:0] man_rounded;
	logic [INT_EXP_WIDTH-1:0] exp_rounded;
	logic inc_exp;
	logic inexact;
	logic sat_to_max;

	logic [31:0] result_comb;
	logic of_comb;
	logic uf_comb;
	logic ie_comb;

	assign src.ready = out_ready;

	// bias and denormalization amount
	always_comb begin
		exp_biased = src.exp + INT_EXP_WIDTH'(EXP_BIAS);
		equal = exp_biased == '0;
		less = exp_biased[INT_EXP_WIDTH-1];
		if (equal || less) begin
			// tiny result, shift right and force the exponent field to zero
			offset = INT_EXP_WIDTH'(1) - exp_biased;
			exp_adj = '0;
		end else begin
			offset = '0;
			exp_adj = exp_biased;
		end
		// large shifts only clear the mantissa, so cap them
		if (|offset[INT_EXP_WIDTH-1:SHIFT_SEL_WIDTH])
			shift_sel = '1;
		else
			shift_sel = offset[SHIFT_SEL_WIDTH-1:0];
	end

	rshifter #(
		.WIDTH(SHIFT_WIDTH),
		.SEL_WIDTH(SHIFT_SEL_WIDTH)
	) rshifter_i (
		.in({src.man, src.round_bit}),
		.sel(shift_sel),
		.out(shifter_out),
		.sticky_bit(shift_sticky)
	);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (src.valid && src.ready) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (src.valid && src.ready) begin
			reg_rm <= src.rm;
			reg_sgn <= src.sgn;
			reg_skip_round <= src.skip_round;
			reg_iv <= src.iv;
			if (src.skip_round) begin
				reg_man <= src.man[MAN_WIDTH-1:0];
				reg_exp <= src.exp;
				reg_round_bit <= 1'b0;
				reg_sticky_bit <= 1'b0;
				reg_equal <= 1'b0;
				reg_less <= 1'b0;
			end else begin
				reg_man <= shifter_out[MAN_WIDTH:1];
				reg_exp <= exp_adj;
				reg_round_bit <= shifter_out[0];
				reg_sticky_bit <= src.sticky_bit || shift_sticky;
				reg_equal <= equal;
				reg_less <= less;
			end
		end
	end

	rounding_logic #(
		.WIDTH(MAN_WIDTH)
	) rounding_logic_i (
		.rm(reg_rm),
		.in(reg_man),
		.round_bit(reg_round_bit),
		.sticky_bit(reg_sticky_bit),
		.sgn(reg_sgn),
		.out(man_rounded),
		.carry(inc_exp),
		.inexact(inexact)
	);

	// modes that never round away from zero on this sign
	assign sat_to_max = (reg_rm == RTZ) || (reg_rm == RDN && !reg_sgn)
		|| (reg_rm == RUP && reg_sgn);

	always_comb begin
		exp_rounded = reg_exp + INT_EXP_WIDTH'(inc_exp);
		result_comb = {reg_sgn, reg_exp[EXP_WIDTH-1:0], reg_man};
		of_comb = 1'b0;
		uf_comb = 1'b0;
		ie_comb = 1'b0;
		if (!reg_skip_round) begin
			if (exp_rounded >= INT_EXP_WIDTH'(2 ** EXP_WIDTH - 1)) begin
				of_comb = 1'b1;
				ie_comb = 1'b1;
				if (sat_to_max)
					result_comb = {reg_sgn, {(EXP_WIDTH - 1){1'b1}}, 1'b0, {MAN_WIDTH{1'b1}}};
				else
					result_comb = {reg_sgn, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};
			end else begin
				ie_comb = inexact;
				// tiny after rounding
				uf_comb = inexact && (reg_less || (reg_equal && !inc_exp));
				result_comb = {reg_sgn, exp_rounded[EXP_WIDTH-1:0], man_rounded};
			end
		end
	end

	assign float_out = result_comb;
	assign iv = out_valid && reg_iv;
	assign of = out_valid && of_comb;
	assign uf = out_valid && uf_comb;
	assign ie = out_valid && ie_comb;

endmodule

/* source/fpu_mul_top.sv */
module fpu_mul_top import fpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] operand_a,
	input logic [31:0] operand_b,
	input rounding_mode_t rm,
	output logic out_valid,
	input logic out_ready,
	output logic [31:0] result,
	output logic flag_iv,
	output logic flag_of,
	output logic flag_uf,
	output logic flag_ie
);

	// unrounded product between the two stages
	fpu_result_if result_if ();

	fpu_multiplier multiplier_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.rm(rm),
		.res(result_if.producer)
	);

	post_processor post_processor_i (
		.clk(clk),
		.reset(reset),
		.src(result_if.consumer),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.float_out(result),
		.iv(flag_iv),
		.of(flag_of),
		.uf(flag_uf),
		.ie(flag_ie)
	);

endmodule

/* verification/clock_gen.sv */
module clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held for the first ten rising edges
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

/* verification/fpu_mul_assertions.sv */
module fpu_mul_assertions (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input logic out_ready,
	input logic [31:0] result,
	input logic flag_iv,
	input logic flag_of,
	input logic flag_uf,
	input logic flag_ie
);

	int failures = 0;

	reset_clears_valid: assert property (@(posedge clk) reset |-> !out_valid)
		else begin
			$error("out_valid high during reset");
			failures++;
		end

	// output held until the consumer takes it
	held_under_backpressure: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(result)
		&& $stable({flag_iv, flag_of, flag_uf, flag_ie}))
		else begin
			$error("output changed while out_ready was low");
			failures++;
		end

	of_implies_ie: assert property (@(posedge clk) disable iff (reset) flag_of |-> flag_ie)
		else begin
			$error("overflow without inexact");
			failures++;
		end

	uf_implies_ie: assert property (@(posedge clk) disable iff (reset) flag_uf |-> flag_ie)
		else begin
			$error("underflow without inexact");
			failures++;
		end

	flags_low_when_idle: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> !(flag_iv || flag_of || flag_uf || flag_ie))
		else begin
			$error("flag raised while out_valid is low");
			failures++;
		end

endmodule

bind fpu_mul_top fpu_mul_assertions assertions_i (.*);

/* verification/fpu_mul_tb.sv */
module fpu_mul_tb import fpu_pkg::*; ();

	localparam int CAT_NORMAL = 0;
	localparam int CAT_OVERFLOW = 1;
	localparam int CAT_TINY = 2;
	localparam int CAT_SPECIAL = 3;
	localparam int CAT_STALL = 4;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [31:0] operand_a;
	logic [31:0] operand_b;
	rounding_mode_t rm;
	logic out_valid;
	logic out_ready;
	logic [31:0] result;
	logic flag_iv;
	logic flag_of;
	logic flag_uf;
	logic flag_ie;

	integer seed;
	int errors = 0;
	int checked = 0;
	int cycle = 0;
	int stalls = 0;
	int cur_cat;

	// expected {result, iv, of, uf, ie} plus bookkeeping per item
	logic [35:0] exp_q[$];
	int cat_q[$];
	int cycle_q[$];
	int stall_q[$];

	clock_gen clock_gen_i (
		.clk(clk),
		.reset(reset)
	);

	fpu_mul_top dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.rm(rm),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.flag_iv(flag_iv),
		.flag_of(flag_of),
		.flag_uf(flag_uf),
		.flag_ie(flag_ie)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout: %s", what);
		$display("errors: %0d, results checked: %0d", errors + 1, checked);
		$display("sim failed");
		$finish;
	endtask

	function automatic string name_of(input int cat);
		case (cat)
			CAT_NORMAL: return "normal";
			CAT_OVERFLOW: return "overflow";
			CAT_TINY: return "tiny";
			CAT_SPECIAL: return "special";
			default: return "backpressure";
		endcase
	endfunction

	// reference multiply on integer significands
	function automatic logic [35:0] multiply_model(input logic [31:0] a, input logic [31:0] b,
			input rounding_mode_t m);
		int ea;
		int eb;
		int e;
		int rs;
		int biased;
		logic s;
		logic a_nan;
		logic b_nan;
		logic a_inf;
		logic b_inf;
		logic a_zero;
		logic b_zero;
		logic inf_zero;
		logic [63:0] p;
		logic [63:0] kept;
		logic rnd;
		logic stk;
		logic up;
		logic [31:0] res;
		logic iv;
		logic of;
		logic uf;
		logic ie;
		ea = a[30:23];
		eb = b[30:23];
		s = a[31] ^ b[31];
		iv = 1'b0;
		of = 1'b0;
		uf = 1'b0;
		ie = 1'b0;
		// denormal inputs read as zero
		a_zero = ea == 0;
		b_zero = eb == 0;
		a_inf = ea == 255 && a[22:0] == 0;
		b_inf = eb == 255 && b[22:0] == 0;
		a_nan = ea == 255 && a[22:0] != 0;
		b_nan = eb == 255 && b[22:0] != 0;
		inf_zero = (a_inf && b_zero) || (b_inf && a_zero);
		if (a_nan || b_nan || inf_zero) begin
			res = CANONICAL_NAN;
			iv = (a_nan && !a[22]) || (b_nan && !b[22]) || inf_zero;
		end else if (a_inf || b_inf) begin
			res = {s, 8'hff, 23'd0};
		end else if (a_zero || b_zero) begin
			res = {s, 31'd0};
		end else begin
			p = 64'({1'b1, a[22:0]}) * 64'({1'b1, b[22:0]});
			e = ea + eb - 254 + int'(p[47]);
			// last kept bit sits on the normal grid or on 2^-149
			rs = ((e >= -126) ? e - 23 : -149) - (ea + eb - 300);
			if (rs > 60)
				rs = 60;
			kept = p >> rs;
			rnd = p[rs - 1];
			stk = (p & ((64'd1 << (rs - 1)) - 1)) != 0;
			ie = rnd || stk;
			case (m)
				RNE: up = rnd && (stk || kept[0]);
				RDN: up = s && ie;
				RUP: up = !s && ie;
				RMM: up = rnd;
				default: up = 1'b0;
			endcase
			kept = kept + 64'(up);
			if (e >= -126) begin
				biased = e + 127;
				if (kept[24]) begin
					biased++;
					kept = kept >> 1;
				end
				if (biased >= 255) begin
					of = 1'b1;
					ie = 1'b1;
					if (m == RTZ || (m == RDN && !s) || (m == RUP && s))
						res = {s, 8'hfe, 23'h7fffff};
					else
						res = {s, 8'hff, 23'd0};
				end else begin
					res = {s, biased[7:0], kept[22:0]};
				end
			end else begin
				// a carry into bit 23 gives the smallest normal
				res = {s, 7'd0, kept[23], kept[22:0]};
				uf = ie && ((e + 127 < 0) || (e + 127 == 0 && !kept[23]));
			end
		end
		return {res, iv, of, uf, ie};
	endfunction

	always @(posedge clk) begin : scoreboard
		logic [35:0] expected;
		string name;
		int pushed_stalls;
		int latency;
		if (!reset) begin
			cycle++;
			if (!out_ready)
				stalls++;
			check_value("in_ready", out_ready, in_ready);
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("a result came out with no operands pending");
				end else begin
					expected = exp_q.pop_front();
					name = name_of(cat_q.pop_front());
					latency = cycle - cycle_q.pop_front();
					pushed_stalls = stall_q.pop_front();
					check_value({name, " result"}, expected[35:4], result);
					check_value({name, " iv"}, expected[3], flag_iv);
					check_value({name, " of"}, expected[2], flag_of);
					check_value({name, " uf"}, expected[1], flag_uf);
					check_value({name, " ie"}, expected[0], flag_ie);
					// no back-pressure since the input was taken
					if (pushed_stalls == stalls)
						check_value({name, " latency"}, 2, latency);
					checked++;
				end
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(multiply_model(operand_a, operand_b, rm));
				cat_q.push_back(cur_cat);
				cycle_q.push_back(cycle);
				stall_q.push_back(stalls);
			end
		end
	end

	task automatic set_ready(input bit bp);
		if (bp)
			out_ready = ($random(seed) & 3) != 0;
		else
			out_ready = 1'b1;
	endtask

	task automatic normal_operand(input int exp_lo, input int exp_span, output logic [31:0] op);
		int e;
		e = exp_lo + int'($unsigned($random(seed)) % exp_span);
		op = {1'($random(seed)), 8'(e), 23'($random(seed))};
	endtask

	task automatic special_operand(output logic [31:0] op);
		logic s;
		logic [22:0] f;
		{s, f} = 24'($random(seed));
		case ($unsigned($random(seed)) % 8)
			0: op = {s, 31'd0};
			1: op = {s, 8'hff, 23'd0};
			2: op = {s, 8'hff, 1'b1, f[21:0]};
			3: op = {s, 8'hff, 1'b0, f[21:1], 1'b1};
			4: op = {s, 8'h00, f[22:1], 1'b1};
			default: normal_operand(1, 254, op);
		endcase
	endtask

	task automatic send_item(input logic [31:0] a, input logic [31:0] b,
			input rounding_mode_t m, input int cat, input bit bp);
		int waited;
		bit accepted;
		waited = 0;
		accepted = 1'b0;
		// occasional idle cycle between items
		if (bp && ($random(seed) & 3) == 0) begin
			in_valid = 1'b0;
			@(posedge clk);
			#1;
			set_ready(bp);
		end
		in_valid = 1'b1;
		operand_a = a;
		operand_b = b;
		rm = m;
		cur_cat = cat;
		while (!accepted) begin
			@(posedge clk);
			accepted = in_ready;
			#1;
			set_ready(bp);
			waited++;
			if (!accepted && waited > 200)
				fail_timeout("operands were never accepted");
		end
	endtask

	task automatic run_phase(input int cat, input int count, input bit bp);
		logic [31:0] a;
		logic [31:0] b;
		rounding_mode_t m;
		for (int i = 0; i < count; i++) begin
			if (cat == CAT_OVERFLOW) begin
				normal_operand(190, 65, a);
				normal_operand(190, 65, b);
			end else if (cat == CAT_TINY) begin
				normal_operand(50, 40, a);
				normal_operand(40, 40, b);
			end else if (cat == CAT_SPECIAL) begin
				special_operand(a);
				special_operand(b);
			end else begin
				normal_operand(64, 127, a);
				normal_operand(64, 127, b);
			end
			if (bp)
				m = rounding_mode_t'($unsigned($random(seed)) % 5);
			else
				m = rounding_mode_t'(i % 5);
			send_item(a, b, m, cat, bp);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		in_valid = 1'b0;
		out_ready = 1'b1;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 50)
				fail_timeout("pipeline did not drain");
		end
		// catch any extra result
		repeat (5) @(posedge clk);
	endtask

	initial begin
		int waited;
		seed = 94;
		in_valid = 1'b0;
		operand_a = '0;
		operand_b = '0;
		rm = RNE;
		out_ready = 1'b0;
		cur_cat = CAT_NORMAL;
		waited = 0;
		while (reset !== 1'b0) begin
			@(posedge clk);
			waited++;
			if (waited > 100)
				fail_timeout("reset was never released");
		end
		#1;
		out_ready = 1'b1;
		run_phase(CAT_NORMAL, 200, 1'b0);
		run_phase(CAT_OVERFLOW, 150, 1'b1);
		run_phase(CAT_TINY, 200, 1'b1);
		run_phase(CAT_SPECIAL, 150, 1'b1);
		run_phase(CAT_STALL, 150, 1'b1);
		drain_pipeline();
		errors = errors + dut_i.assertions_i.failures;
		$display("errors: %0d, results checked: %0d", errors, checked);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* all.f */
source/fpu_pkg.sv
source/fpu_result_if.sv
source/rshifter.sv
source/rounding_logic.sv
source/fpu_multiplier.sv
source/post_processor.sv
source/fpu_mul_top.sv
verification/clock_gen.sv
verification/fpu_mul_assertions.sv
verification/fpu_mul_tb.sv
